// ==== all.f ====
+incdir+bench
source/ex_pkg.sv
source/ex_input_reg.sv
source/operand_select.sv
source/ex_alu.sv
source/branch_unit.sv
source/csr_write_ctrl.sv
source/ex_stage.sv
bench/tb_ex_stage.sv

// ==== bench/tb_ex_checks.svh ====
`ifndef TB_EX_CHECKS_SVH
`define TB_EX_CHECKS_SVH

// 64-bit lcg (mmix constants)
// halves swapped so the weak low bits end up on top
function automatic xlen_t lcg_next();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return {lcg_state[31:0], lcg_state[63:32]};
endfunction

// expected alu result, from the rv64i definitions
function automatic xlen_t alu_model(ex_req_t r);
    xlen_t       a;
    xlen_t       b;
    logic [31:0] w;
    a = r.src_a;
    b = r.src_b;
    w = '0;
    // immediate forms take b from imm or from the shamt field
    case (r.op)
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_ADDIW,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_STORE: b = r.imm;
        OP_SLLI, OP_SRLI, OP_SRAI:    b = xlen_t'(r.inst[25:20]);
        OP_SLLIW, OP_SRLIW, OP_SRAIW: b = xlen_t'(r.inst[24:20]);
        default: ;
    endcase
    case (r.op)
        OP_SUB:                  return a - b;
        OP_SLL, OP_SLLI:         return a << b[5:0];
        OP_SLT, OP_SLTI:         return xlen_t'($signed(a) < $signed(b));
        OP_SLTU, OP_SLTIU:       return xlen_t'(a < b);
        OP_XOR, OP_XORI:         return a ^ b;
        OP_SRL, OP_SRLI:         return a >> b[5:0];
        OP_SRA, OP_SRAI:         return $signed(a) >>> b[5:0];
        OP_OR, OP_ORI, OP_CSRRS: return a | b;
        OP_AND, OP_ANDI:         return a & b;
        OP_LUI:                  return b;
        OP_AUIPC, OP_JAL:        return r.pc + b;
        // word ops, only the low 32 bits count
        OP_ADDW, OP_ADDIW:       w = a[31:0] + b[31:0];
        OP_SUBW:                 w = a[31:0] - b[31:0];
        OP_SLLW, OP_SLLIW:       w = a[31:0] << b[4:0];
        OP_SRLW, OP_SRLIW:       w = a[31:0] >> b[4:0];
        OP_SRAW, OP_SRAIW:       w = $signed(a[31:0]) >>> b[4:0];
        // add, jalr, address sums, branches, bubble
        default:                 return a + b;
    endcase
    return {{32{w[31]}}, w};
endfunction

// next pc, redirect flag through redir
function automatic xlen_t npc_model(ex_req_t r, output logic redir);
    xlen_t off;
    logic  take;
    // b-type offset, imm[12|10:5] and imm[4:1|11]
    off   = {{52{r.inst[31]}}, r.inst[7], r.inst[30:25], r.inst[11:8], 1'b0};
    redir = 1'b1;
    take  = 1'b0;
    case (r.op)
        OP_JAL:            return r.pc + r.imm;
        OP_JALR:           return (r.src_a + r.imm) & ~xlen_t'(1);
        OP_ECALL, OP_MRET: return r.src_b;
        OP_BEQ:  take = r.src_a == r.src_b;
        OP_BNE:  take = r.src_a != r.src_b;
        OP_BLT:  take = $signed(r.src_a) < $signed(r.src_b);
        OP_BGE:  take = $signed(r.src_a) >= $signed(r.src_b);
        OP_BLTU: take = r.src_a < r.src_b;
        OP_BGEU: take = r.src_a >= r.src_b;
        default: redir = 1'b0;
    endcase
    return take ? r.pc + off : r.pc + 64'd4;
endfunction

// csr writes for one request
function automatic csr_wr_t csr_model(ex_req_t r);
    csr_wr_t c;
    xlen_t   d;
    logic    csr;
    logic    ecall;
    csr   = (r.op == OP_CSRRW) || (r.op == OP_CSRRS);
    ecall = r.op == OP_ECALL;
    // csrrs sets bits in the old value from src_b
    d = (r.op == OP_CSRRS) ? (r.src_a | r.src_b) : r.src_a;
    c.mtvec_wen     = csr && (r.inst[31:20] == CSR_MTVEC);
    c.mepc_wen      = ecall || (csr && (r.inst[31:20] == CSR_MEPC));
    c.mcause_wen    = ecall || (csr && (r.inst[31:20] == CSR_MCAUSE));
    c.mstatus_wen   = csr && (r.inst[31:20] == CSR_MSTATUS);
    c.mtvec_wdata   = c.mtvec_wen ? d : '0;
    // trap entry, pc into mepc and environment call cause 11
    c.mepc_wdata    = ecall ? r.pc : (c.mepc_wen ? d : '0);
    c.mcause_wdata  = ecall ? 64'd11 : (c.mcause_wen ? d : '0);
    c.mstatus_wdata = c.mstatus_wen ? d : '0;
    return c;
endfunction

task automatic check_word(string name, xlen_t exp, xlen_t act);
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s expected %h got %h at %0t", name, exp, act, $time);
    end
endtask

task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s expected %h got %h at %0t", name, exp, act, $time);
    end
endtask

task automatic check_inst(string name, inst_t exp, inst_t act);
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s expected %h got %h at %0t", name, exp, act, $time);
    end
endtask

task automatic check_op(string name, ex_op_e exp, ex_op_e act);
    if (act !== exp) begin
        errors++;
        $display("[FAIL] %s expected %h got %h at %0t", name, exp, act, $time);
    end
endtask

task automatic check_csr(csr_wr_t exp, csr_wr_t act);
    check_bit("csr_wr.mtvec_wen", exp.mtvec_wen, act.mtvec_wen);
    check_bit("csr_wr.mepc_wen", exp.mepc_wen, act.mepc_wen);
    check_bit("csr_wr.mcause_wen", exp.mcause_wen, act.mcause_wen);
    check_bit("csr_wr.mstatus_wen", exp.mstatus_wen, act.mstatus_wen);
    check_word("csr_wr.mtvec_wdata", exp.mtvec_wdata, act.mtvec_wdata);
    check_word("csr_wr.mepc_wdata", exp.mepc_wdata, act.mepc_wdata);
    check_word("csr_wr.mcause_wdata", exp.mcause_wdata, act.mcause_wdata);
    check_word("csr_wr.mstatus_wdata", exp.mstatus_wdata, act.mstatus_wdata);
endtask

`endif

// ==== bench/tb_ex_stage.sv ====
`timescale 1ns/100ps

module tb_ex_stage;
    import ex_pkg::*;

    logic    clk;
    logic    rst;
    logic    valid_in;
    ex_req_t req;
    logic    valid_out;
    ex_out_t out;
    xlen_t   dnpc;
    logic    pc_update;
    csr_wr_t csr_wr;

    int      errors;
    xlen_t   lcg_state;
    // request driven last cycle, its results show now
    ex_req_t prev_req;
    logic    prev_valid;

    `include "tb_ex_checks.svh"

    ex_stage i_ex_stage (.*);

    // 20 ns period
    always #10 clk = ~clk;

    // all outputs against the models for last cycle's request
    task automatic check_stage();
        xlen_t exp_pc;
        logic  exp_redir;
        exp_pc = npc_model(prev_req, exp_redir);
        check_bit("valid_out", prev_valid, valid_out);
        check_word("out.pc", prev_req.pc, out.pc);
        check_inst("out.inst", prev_req.inst, out.inst);
        check_op("out.op", prev_req.op, out.op);
        check_word("out.src_b", prev_req.src_b, out.src_b);
        check_word("dnpc", exp_pc, dnpc);
        check_bit("pc_update", exp_redir, pc_update);
        check_csr(csr_model(prev_req), csr_wr);
        // no alu value defined for these
        if (prev_req.op != OP_CSRRW && prev_req.op != OP_ECALL && prev_req.op != OP_MRET) begin
            check_word("out.alu_result", alu_model(prev_req), out.alu_result);
        end
    endtask

    // falling edge: check previous, then drive the next one
    task automatic step(ex_req_t r, logic v);
        @(negedge clk);
        check_stage();
        valid_in   = v;
        req        = r;
        // bubble shows up as an all-zero request
        prev_req   = v ? r : '0;
        prev_valid = v;
    endtask

    function automatic ex_req_t make_req(ex_op_e op);
        ex_req_t r;
        r.pc    = lcg_next() & ~xlen_t'(3);
        r.inst  = inst_t'(lcg_next());
        r.op    = op;
        r.src_a = lcg_next();
        r.src_b = lcg_next();
        r.imm   = lcg_next();
        return r;
    endfunction

    // reg, imm and 64-bit shift ops, 20 random requests each
    task automatic test_alu();
        for (int k = OP_ADD; k <= OP_SRAI; k++) begin
            repeat (20) step(make_req(ex_op_e'(k)), 1'b1);
        end
        step(make_req(OP_LUI), 1'b1);
        step(make_req(OP_AUIPC), 1'b1);
        step(make_req(OP_LOAD), 1'b1);
        step(make_req(OP_STORE), 1'b1);
    endtask

    task automatic test_word();
        ex_req_t r;
        for (int k = OP_ADDW; k <= OP_SRAIW; k++) begin
            repeat (20) begin
                r = make_req(ex_op_e'(k));
                // negative low words, so sign extension matters
                r.src_a[31] = 1'b1;
                r.src_b[31] = 1'b1;
                step(r, 1'b1);
            end
        end
    endtask

    task automatic test_flow();
        ex_req_t r;
        xlen_t   neg;
        xlen_t   pos;
        step(make_req(OP_JAL), 1'b1);
        r = make_req(OP_JALR);
        // odd sum, bit 0 of the target has to drop
        r.src_a[0] = 1'b1;
        r.imm[0]   = 1'b0;
        step(r, 1'b1);
        // signed and unsigned order disagree on this pair
        neg = lcg_next() | {1'b1, 63'b0};
        pos = lcg_next() & {1'b0, {63{1'b1}}};
        for (int k = OP_BEQ; k <= OP_BGEU; k++) begin
            // equal, neg vs pos, pos vs neg
            for (int j = 0; j < 3; j++) begin
                r = make_req(ex_op_e'(k));
                r.src_a = (j == 2) ? pos : neg;
                r.src_b = (j == 1) ? pos : neg;
                step(r, 1'b1);
            end
        end
        step(make_req(OP_ECALL), 1'b1);
        step(make_req(OP_MRET), 1'b1);
        step(make_req(OP_ADD), 1'b1);
    endtask

    task automatic test_csr();
        // last one is not a machine csr
        logic [11:0] addr [5] = '{CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MSTATUS, 12'h7c0};
        ex_req_t     r;
        for (int k = OP_CSRRW; k <= OP_CSRRS; k++) begin
            foreach (addr[j]) begin
                r = make_req(ex_op_e'(k));
                r.inst[31:20] = addr[j];
                step(r, 1'b1);
            end
        end
        step(make_req(OP_ECALL), 1'b1);
    endtask

    // back to back mix with one bubble
    task automatic test_stream();
        ex_req_t r;
        r = make_req(OP_CSRRW);
        r.inst[31:20] = CSR_MTVEC;
        step(make_req(OP_ADD), 1'b1);
        step(make_req(OP_SRAW), 1'b1);
        step(make_req(OP_BLTU), 1'b1);
        step(r, 1'b1);
        // junk under a low valid must stay masked
        step(make_req(OP_ECALL), 1'b0);
        step(make_req(OP_ECALL), 1'b1);
        step(make_req(OP_JALR), 1'b1);
        step(make_req(OP_ORI), 1'b1);
        step('0, 1'b0);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        errors     = 0;
        lcg_state  = 64'd5648;
        // live ecall held in during reset, none of it may get through
        valid_in   = 1'b1;
        req        = make_req(OP_ECALL);
        prev_req   = '0;
        prev_valid = 1'b0;
        // 4 reset cycles, outputs idle from the first edge on
        repeat (4) begin
            @(negedge clk);
            check_stage();
        end
        rst      = 1'b0;
        valid_in = 1'b0;
        req      = '0;
        test_alu();
        test_word();
        test_flow();
        test_csr();
        test_stream();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== source/branch_unit.sv ====
`timescale 1ns/100ps

module branch_unit (
    input  ex_pkg::ex_req_t cur,
    input  ex_pkg::xlen_t   alu_result,
    output ex_pkg::xlen_t   dnpc,
    output logic            pc_update
);
    import ex_pkg::*;

    xlen_t imm_b;
    xlen_t snpc;
    xlen_t br_target;

    // b-type offset straight from the instruction word
    assign imm_b = {{51{cur.inst[31]}}, cur.inst[31], cur.inst[7],
                    cur.inst[30:25], cur.inst[11:8], 1'b0};

    assign snpc      = cur.pc + xlen_t'(4);
    assign br_target = cur.pc + imm_b;

    always_comb begin
        dnpc      = snpc;
        pc_update = 1'b1;
        case (cur.op)
            // jump targets come out of the alu add
            OP_JAL:  dnpc = alu_result;
            OP_JALR: dnpc = {alu_result[XLEN-1:1], 1'b0};
            OP_BEQ:  dnpc = (cur.src_a == cur.src_b) ? br_target : snpc;
            OP_BNE:  dnpc = (cur.src_a != cur.src_b) ? br_target : snpc;
            OP_BLT: begin
                dnpc = ($signed(cur.src_a) < $signed(cur.src_b)) ? br_target : snpc;
            end
            OP_BGE: begin
                dnpc = ($signed(cur.src_a) >= $signed(cur.src_b)) ? br_target : snpc;
            end
            OP_BLTU: dnpc = (cur.src_a < cur.src_b) ? br_target : snpc;
            OP_BGEU: dnpc = (cur.src_a >= cur.src_b) ? br_target : snpc;
            // trap vector or mepc, read by decode
            OP_ECALL, OP_MRET: dnpc = cur.src_b;
            // sequential flow, fetch keeps its own pc
            default: pc_update = 1'b0;
        endcase
    end

    // jalr redirect is rs1 + imm on an even address
    // operand mux and alu add have to agree on it
    jalr_aligned_a: assert final (
        !(pc_update && cur.op == OP_JALR) ||
        dnpc == ((cur.src_a + cur.imm) & ~xlen_t'(1))
    );

endmodule

// ==== source/csr_write_ctrl.sv ====
`timescale 1ns/100ps

module csr_write_ctrl #(
    parameter ex_pkg::xlen_t ECALL_CAUSE = 64'd11
) (
    input  ex_pkg::ex_req_t cur,
    input  ex_pkg::xlen_t   alu_result,
    output ex_pkg::csr_wr_t csr_wr
);
    import ex_pkg::*;

    logic [11:0] csr_addr;
    xlen_t       csr_data;
    logic        csr_op;

    // csr number sits in the i-type immediate field
    assign csr_addr = cur.inst[31:20];
    assign csr_op   = (cur.op == OP_CSRRW) || (cur.op == OP_CSRRS);
    // csrrw writes rs1, csrrs writes rs1 | old value
    assign csr_data = (cur.op == OP_CSRRW) ? cur.src_a : alu_result;

    always_comb begin
        csr_wr = '0;
        if (csr_op) begin
            // unknown address writes nothing
            case (csr_addr)
                CSR_MTVEC: begin
                    csr_wr.mtvec_wen   = 1'b1;
                    csr_wr.mtvec_wdata = csr_data;
                end
                CSR_MEPC: begin
                    csr_wr.mepc_wen   = 1'b1;
                    csr_wr.mepc_wdata = csr_data;
                end
                CSR_MCAUSE: begin
                    csr_wr.mcause_wen   = 1'b1;
                    csr_wr.mcause_wdata = csr_data;
                end
                CSR_MSTATUS: begin
                    csr_wr.mstatus_wen   = 1'b1;
                    csr_wr.mstatus_wdata = csr_data;
                end
                default: ;
            endcase
        end else if (cur.op == OP_ECALL) begin
            // trap entry saves the faulting pc and the cause
            csr_wr.mepc_wen     = 1'b1;
            csr_wr.mepc_wdata   = cur.pc;
            csr_wr.mcause_wen   = 1'b1;
            csr_wr.mcause_wdata = ECALL_CAUSE;
        end
    end

    // only a trap touches two csrs at once
    one_csr_write_a: assert final (
        cur.op == OP_ECALL ||
        $countones({csr_wr.mtvec_wen, csr_wr.mepc_wen,
                    csr_wr.mcause_wen, csr_wr.mstatus_wen}) <= 1
    );

endmodule

// ==== source/ex_alu.sv ====
`timescale 1ns/100ps

module ex_alu (
    input  ex_pkg::alu_fn_e  alu_fn,
    input  ex_pkg::res_fmt_e res_fmt,
    input  ex_pkg::xlen_t    opnd_a,
    input  ex_pkg::xlen_t    opnd_b,
    output ex_pkg::xlen_t    result
);
    import ex_pkg::*;

    logic [5:0] shamt;
    xlen_t      raw;
    logic       lt_s;
    logic       lt_u;

    // only the low 6 bits of b count for shifts
    assign shamt = opnd_b[5:0];
    assign lt_s  = $signed(opnd_a) < $signed(opnd_b);
    assign lt_u  = opnd_a < opnd_b;

    always_comb begin
        case (alu_fn)
            ALU_ADD:  raw = opnd_a + opnd_b;
            ALU_SUB:  raw = opnd_a - opnd_b;
            // compares give 0 or 1
            ALU_SLT:  raw = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: raw = {{(XLEN-1){1'b0}}, lt_u};
            ALU_AND:  raw = opnd_a & opnd_b;
            ALU_OR:   raw = opnd_a | opnd_b;
            ALU_XOR:  raw = opnd_a ^ opnd_b;
            ALU_SLL:  raw = opnd_a << shamt;
            ALU_SRL:  raw = opnd_a >> shamt;
            ALU_SRA:  raw = xlen_t'($signed(opnd_a) >>> shamt);
            default:  raw = '0;
        endcase
    end

    // word results sign extended from whichever half holds them
    always_comb begin
        case (res_fmt)
            RES_LOW_SEXT:  result = {{32{raw[31]}}, raw[31:0]};
            RES_HIGH_SEXT: result = {{32{raw[XLEN-1]}}, raw[XLEN-1:32]};
            default:       result = raw;
        endcase
    end

endmodule

// ==== source/ex_input_reg.sv ====
`timescale 1ns/100ps

module ex_input_reg (
    input  logic            clk,
    input  logic            rst,
    input  logic            valid_in,
    input  ex_pkg::ex_req_t req,
    output ex_pkg::ex_req_t cur,
    output logic            cur_valid
);
    import ex_pkg::*;

    ex_req_t req_q;
    logic    valid_q;

    // id/ex pipeline register
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            req_q   <= '0;
        end else begin
            valid_q <= valid_in;
            req_q   <= req;
        end
    end

    // bubble slots become OP_NONE with zero fields
    // so nothing downstream has to look at valid
    always_comb begin
        cur    = '0;
        cur.op = OP_NONE;
        if (valid_q) begin
            cur = req_q;
        end
    end

    assign cur_valid = valid_q;

    // no stale instruction leaks out of reset
    rst_clears_valid_a: assert property (
        @(posedge clk) rst |=> !cur_valid
    );

endmodule

// ==== source/ex_pkg.sv ====
package ex_pkg;

    // data path width of the core
    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     inst_t;

    // machine csr addresses, as in inst[31:20]
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // internal operation code from decode
    // OP_NONE must stay at zero, masked slots rely on it
    typedef enum logic [5:0] {
        OP_NONE,
        // register-register
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        // register-immediate
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        // 32-bit word forms
        OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
        OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
        // upper immediates and jumps
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        // conditional branches
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        // address sum only, access happens in mem
        OP_LOAD, OP_STORE,
        // system
        OP_CSRRW, OP_CSRRS, OP_ECALL, OP_MRET
    } ex_op_e;

    // alu functions
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_fn_e;

    // how the raw alu word is shaped into the result
    typedef enum logic [1:0] {
        RES_FULL,
        RES_LOW_SEXT,
        RES_HIGH_SEXT
    } res_fmt_e;

    // decoded instruction entering execute
    typedef struct packed {
        xlen_t  pc;
        inst_t  inst;
        ex_op_e op;
        xlen_t  src_a;
        xlen_t  src_b;
        xlen_t  imm;
    } ex_req_t;

    // instruction handed on to memory
    typedef struct packed {
        xlen_t  pc;
        inst_t  inst;
        ex_op_e op;
        xlen_t  alu_result;
        // store data rides along in src_b
        xlen_t  src_b;
    } ex_out_t;

    // csr write port, data zero while its enable is low
    typedef struct packed {
        logic  mtvec_wen;
        logic  mepc_wen;
        logic  mcause_wen;
        logic  mstatus_wen;
        xlen_t mtvec_wdata;
        xlen_t mepc_wdata;
        xlen_t mcause_wdata;
        xlen_t mstatus_wdata;
    } csr_wr_t;

endpackage

// ==== source/ex_stage.sv ====
`timescale 1ns/100ps

module ex_stage #(
    parameter ex_pkg::xlen_t ECALL_CAUSE = 64'd11
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            valid_in,
    input  ex_pkg::ex_req_t req,
    output logic            valid_out,
    output ex_pkg::ex_out_t out,
    output ex_pkg::xlen_t   dnpc,
    output logic            pc_update,
    output ex_pkg::csr_wr_t csr_wr
);
    import ex_pkg::*;

    ex_req_t  cur;
    logic     cur_valid;
    alu_fn_e  alu_fn;
    res_fmt_e res_fmt;
    xlen_t    opnd_a;
    xlen_t    opnd_b;
    xlen_t    alu_result;

    // only registered point in the stage
    ex_input_reg i_ex_input_reg (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .req       (req),
        .cur       (cur),
        .cur_valid (cur_valid)
    );

    operand_select i_operand_select (
        .cur     (cur),
        .alu_fn  (alu_fn),
        .res_fmt (res_fmt),
        .opnd_a  (opnd_a),
        .opnd_b  (opnd_b)
    );

    ex_alu i_ex_alu (
        .alu_fn  (alu_fn),
        .res_fmt (res_fmt),
        .opnd_a  (opnd_a),
        .opnd_b  (opnd_b),
        .result  (alu_result)
    );

    // redirect to fetch
    branch_unit i_branch_unit (
        .cur        (cur),
        .alu_result (alu_result),
        .dnpc       (dnpc),
        .pc_update  (pc_update)
    );

    csr_write_ctrl #(
        .ECALL_CAUSE (ECALL_CAUSE)
    ) i_csr_write_ctrl (
        .cur        (cur),
        .alu_result (alu_result),
        .csr_wr     (csr_wr)
    );

    // ex/mem payload, valid follows the input register
    assign out = '{
        pc:         cur.pc,
        inst:       cur.inst,
        op:         cur.op,
        alu_result: alu_result,
        src_b:      cur.src_b
    };
    assign valid_out = cur_valid;

endmodule

// ==== source/operand_select.sv ====
`timescale 1ns/100ps

module operand_select (
    input  ex_pkg::ex_req_t  cur,
    output ex_pkg::alu_fn_e  alu_fn,
    output ex_pkg::res_fmt_e res_fmt,
    output ex_pkg::xlen_t    opnd_a,
    output ex_pkg::xlen_t    opnd_b
);
    import ex_pkg::*;

    // 64-bit shift amounts
    xlen_t sh64_reg;
    xlen_t sh64_imm;
    // word shift amounts, 5 bits only
    xlen_t sh32_reg;
    xlen_t sh32_imm;
    // low word of rs1 placed for word right shifts
    xlen_t word_zext;
    xlen_t word_high;

    assign sh64_reg  = {{(XLEN-6){1'b0}}, cur.src_b[5:0]};
    assign sh64_imm  = {{(XLEN-6){1'b0}}, cur.inst[25:20]};
    assign sh32_reg  = {{(XLEN-5){1'b0}}, cur.src_b[4:0]};
    assign sh32_imm  = {{(XLEN-5){1'b0}}, cur.inst[24:20]};
    assign word_zext = {32'b0, cur.src_a[31:0]};
    // sra on the upper half keeps the word sign in bit 63
    assign word_high = {cur.src_a[31:0], 32'b0};

    always_comb begin
        // add of rs1 and rs2 unless told otherwise
        alu_fn  = ALU_ADD;
        res_fmt = RES_FULL;
        opnd_a  = cur.src_a;
        opnd_b  = cur.src_b;
        case (cur.op)
            OP_SUB:  alu_fn = ALU_SUB;
            OP_SLT:  alu_fn = ALU_SLT;
            OP_SLTU: alu_fn = ALU_SLTU;
            OP_XOR:  alu_fn = ALU_XOR;
            OP_OR:   alu_fn = ALU_OR;
            OP_AND:  alu_fn = ALU_AND;
            OP_SLL, OP_SRL, OP_SRA: begin
                alu_fn = (cur.op == OP_SLL) ? ALU_SLL :
                         (cur.op == OP_SRL) ? ALU_SRL : ALU_SRA;
                opnd_b = sh64_reg;
            end
            OP_SLLI, OP_SRLI, OP_SRAI: begin
                alu_fn = (cur.op == OP_SLLI) ? ALU_SLL :
                         (cur.op == OP_SRLI) ? ALU_SRL : ALU_SRA;
                opnd_b = sh64_imm;
            end
            // plain imm adds, jalr target and load/store address
            OP_ADDI, OP_JALR, OP_LOAD, OP_STORE: opnd_b = cur.imm;
            OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI: begin
                alu_fn = (cur.op == OP_SLTI)  ? ALU_SLT  :
                         (cur.op == OP_SLTIU) ? ALU_SLTU :
                         (cur.op == OP_XORI)  ? ALU_XOR  :
                         (cur.op == OP_ORI)   ? ALU_OR   : ALU_AND;
                opnd_b = cur.imm;
            end
            OP_LUI: begin
                opnd_a = '0;
                opnd_b = cur.imm;
            end
            // pc relative
            OP_AUIPC, OP_JAL: begin
                opnd_a = cur.pc;
                opnd_b = cur.imm;
            end
            OP_ADDW, OP_SUBW, OP_ADDIW: begin
                alu_fn  = (cur.op == OP_SUBW) ? ALU_SUB : ALU_ADD;
                res_fmt = RES_LOW_SEXT;
                opnd_b  = (cur.op == OP_ADDIW) ? cur.imm : cur.src_b;
            end
            OP_SLLW, OP_SLLIW: begin
                alu_fn  = ALU_SLL;
                res_fmt = RES_LOW_SEXT;
                opnd_b  = (cur.op == OP_SLLW) ? sh32_reg : sh32_imm;
            end
            // zero upper half so nothing shifts into the word
            OP_SRLW, OP_SRLIW: begin
                alu_fn  = ALU_SRL;
                res_fmt = RES_LOW_SEXT;
                opnd_a  = word_zext;
                opnd_b  = (cur.op == OP_SRLW) ? sh32_reg : sh32_imm;
            end
            // result taken from the high half
            OP_SRAW, OP_SRAIW: begin
                alu_fn  = ALU_SRA;
                res_fmt = RES_HIGH_SEXT;
                opnd_a  = word_high;
                opnd_b  = (cur.op == OP_SRAW) ? sh32_reg : sh32_imm;
            end
            // csr set bits, old value arrives in src_b
            OP_CSRRS: alu_fn = ALU_OR;
            // add, branches, csrrw, ecall, mret, bubble
            default: ;
        endcase
    end

endmodule
